/* files.f */
design/vdf_pkg.sv
design/iteration_controller.sv
design/limb_squarer.sv
design/high_fold.sv
design/low_merge.sv
design/final_correction.sv
design/vdf_square_top.sv
bench/clock_gen.sv
bench/vdf_asserts.sv
bench/tb_top.sv

/* Makefile */
SIM_LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_top: files.f design/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top +verilator+error+limit+1000 > $(SIM_LOG) 2>&1 || true
	cat $(SIM_LOG)
	@if grep -q "Result: FAILED" $(SIM_LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(SIM_LOG)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module tb_top

clean:
	rm -rf obj_dir $(SIM_LOG)

/* bench/tb_top.sv */
module tb_top;
    import vdf_pkg::*;

    localparam int MAX_ITER       = 30;
    localparam int RANDOM_TESTS   = 20;
    localparam int NUM_REQUESTS   = 34;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * (MAX_ITER + 10);

    logic                 clk;
    logic                 reset;
    logic                 start;
    sq_request_t          request;
    logic                 busy;
    logic                 valid;
    logic [VALUE_LEN-1:0] result;

    int tests = 0;
    int errors = 0;
    int valid_count;
    int cycles;

    clock_gen u_clock_gen (
        .clk (clk)
    );

    vdf_square_top DUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .request (request),
        .busy    (busy),
        .valid   (valid),
        .result  (result)
    );

    bind vdf_square_top vdf_asserts u_vdf_asserts (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .busy   (busy),
        .valid  (valid),
        .result (result)
    );

    // operand reduced, then squared mod MODULUS once per iteration.
    function automatic logic [VALUE_LEN-1:0] square_mod(input logic [VALUE_LEN-1:0] operand,
                                                        input int iterations);
        logic [127:0] acc;
        logic [127:0] modulus;
        modulus = {64'b0, MODULUS};
        acc     = {64'b0, operand} % modulus;
        for (int n = 0; n < iterations; n++) begin
            acc = (acc * acc) % modulus;
        end
        return acc[VALUE_LEN-1:0];
    endfunction

    task automatic send_request(input logic [VALUE_LEN-1:0] operand, input int iterations);
        @(posedge clk);
        start              <= 1'b1;
        request.operand    <= operand;
        request.iterations <= COUNT_LEN'(iterations);
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_result(input string name, input logic [VALUE_LEN-1:0] expected);
        logic ok;
        while (valid !== 1'b1) begin
            @(posedge clk);
        end
        ok = (result == expected);
        assert (result == expected) else begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, result);
            errors++;
        end
        tests++;
        $display("%-22s %s", name, ok ? "ok" : "failed");
    endtask

    task automatic run_test(input string name, input logic [VALUE_LEN-1:0] operand,
                            input int iterations);
        logic [VALUE_LEN-1:0] expected;
        expected = square_mod(operand, iterations);
        send_request(operand, iterations);
        wait_result(name, expected);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            valid_count <= 0;
        end else if (valid) begin
            valid_count <= valid_count + 1;
        end
    end

    // run limit from the longest request times the request count.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        logic [VALUE_LEN-1:0] first_expected;
        int                   pulses_before;
        void'($urandom(32'h3975_94f6));
        cycles  = 0;
        reset   = 1'b1;
        start   = 1'b0;
        request = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!busy && !valid) else begin
            $display("busy or valid high directly after reset");
            errors++;
        end

        run_test("zero_iter_zero", 64'd0, 0);
        run_test("zero_iter_one", 64'd1, 0);
        run_test("zero_iter_mod_minus_1", MODULUS - 64'd1, 0);
        run_test("zero_iter_modulus", MODULUS, 0);
        run_test("zero_iter_all_ones", '1, 0);

        run_test("one_iter_fixed", 64'h0123_4567_89AB_CDEF, 1);
        run_test("one_iter_top_bit", 64'h8000_0000_0000_0000, 1);
        run_test("one_iter_all_ones", '1, 1);
        run_test("one_iter_two", 64'd2, 1);

        for (int n = 0; n < RANDOM_TESTS; n++) begin
            run_test($sformatf("random_%0d", n), {$urandom, $urandom},
                     int'($urandom_range(MAX_ITER, 1)));
        end

        run_test("above_mod_modulus", MODULUS, 7);
        run_test("above_mod_plus_one", MODULUS + 64'd1, 12);
        run_test("above_mod_all_ones", '1, MAX_ITER);

        // second start lands while the first request is busy.
        @(posedge clk);
        pulses_before  = valid_count;
        first_expected = square_mod(64'hDEAD_BEEF_0BAD_F00D, 20);
        send_request(64'hDEAD_BEEF_0BAD_F00D, 20);
        while (!busy) begin
            @(posedge clk);
        end
        start              <= 1'b1;
        request.operand    <= 64'h0000_0000_0000_1234;
        request.iterations <= COUNT_LEN'(3);
        @(posedge clk);
        start <= 1'b0;
        wait_result("busy_start_ignored", first_expected);
        repeat (MAX_ITER + 10) @(posedge clk);  // long enough for a stray second result.
        assert (valid_count == pulses_before + 1) else begin
            $display("Mismatch busy_start_ignored valid pulses: expected 1, actual %0d",
                     valid_count - pulses_before);
            errors++;
        end

        $display("tests run %0d, errors %0d, assertion failures %0d",
                 tests, errors, DUT.u_vdf_asserts.failures);
        if (errors == 0 && DUT.u_vdf_asserts.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* bench/vdf_asserts.sv */
module vdf_asserts (
    input logic                          clk,
    input logic                          reset,
    input logic                          start,
    input logic                          busy,
    input logic                          valid,
    input logic [vdf_pkg::VALUE_LEN-1:0] result
);
    import vdf_pkg::*;

    logic in_flight;        // accepted and not yet returned.
    int   failures = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else if (start && !busy) begin
            in_flight <= 1'b1;
        end else if (valid) begin
            in_flight <= 1'b0;
        end
    end

    valid_single_cycle: assert property (@(posedge clk) disable iff (reset) valid |=> !valid)
        else begin
            $error("valid stayed high for more than one cycle");
            failures++;
        end

    result_below_modulus: assert property (
        @(posedge clk) disable iff (reset) valid |-> (result < MODULUS))
        else begin
            $error("result at valid is not below the modulus");
            failures++;
        end

    busy_after_accept: assert property (
        @(posedge clk) disable iff (reset) (start && !busy) |=> busy)
        else begin
            $error("busy did not rise after an accepted start");
            failures++;
        end

    valid_needs_accept: assert property (@(posedge clk) disable iff (reset) valid |-> in_flight)
        else begin
            $error("valid appeared without an accepted request");
            failures++;
        end

    idle_after_reset: assert property (@(posedge clk) reset |=> (!busy && !valid))
        else begin
            $error("busy or valid high after reset");
            failures++;
        end

endmodule

/* bench/clock_gen.sv */
module clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // period of 100 time units.
    always begin
        #50 clk = ~clk;
    end

endmodule

/* design/vdf_square_top.sv */
module vdf_square_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  vdf_pkg::sq_request_t          request,
    output logic                          busy,
    output logic                          valid,
    output logic [vdf_pkg::VALUE_LEN-1:0] result
);
    import vdf_pkg::*;

    limb_vec_t   limbs;
    limb_vec_t   folded;
    limb_vec_t   next_limbs;
    column_vec_t columns;
    logic        finish_load;
    logic        done;

    iteration_controller u_iteration_controller (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .request     (request),
        .next_limbs  (next_limbs),
        .done        (done),
        .limbs       (limbs),
        .finish_load (finish_load),
        .busy        (busy),
        .valid       (valid)
    );

    // one squaring per cycle through this combinational loop.
    limb_squarer u_limb_squarer (
        .limbs   (limbs),
        .columns (columns)
    );

    high_fold u_high_fold (
        .columns (columns),
        .folded  (folded)
    );

    low_merge u_low_merge (
        .columns    (columns),
        .folded     (folded),
        .next_limbs (next_limbs)
    );

    final_correction u_final_correction (
        .clk    (clk),
        .reset  (reset),
        .load   (finish_load),
        .limbs  (limbs),
        .done   (done),
        .result (result)
    );

endmodule

/* design/final_correction.sv */
module final_correction (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load,
    input  vdf_pkg::limb_vec_t            limbs,
    output logic                          done,
    output logic [vdf_pkg::VALUE_LEN-1:0] result
);
    import vdf_pkg::*;

    logic [VALUE_LEN+1:0] resolved;
    logic [VALUE_LEN+1:0] value;    // headroom above the modulus width.
    logic                 active;
    logic                 below;

    // carry resolve of the redundant limbs.
    always_comb begin
        resolved = '0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            resolved = resolved + ((VALUE_LEN+2)'(limbs[w]) << (w * WORD_LEN));
        end
    end

    assign below = (value < {2'b00, MODULUS});

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load) begin
                active <= 1'b1;
            end else if (active && below) begin
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            value <= resolved;
        end else if (active && !below) begin
            value <= value - {2'b00, MODULUS}; // one subtraction per cycle.
        end
        if (!load && active && below) begin
            result <= value[VALUE_LEN-1:0];
        end
    end

endmodule

/* design/low_merge.sv */
module low_merge (
    input  vdf_pkg::column_vec_t columns,
    input  vdf_pkg::limb_vec_t   folded,
    output vdf_pkg::limb_vec_t   next_limbs
);
    import vdf_pkg::*;

    sum_vec_t sums;

    always_comb begin
        for (int w = 0; w < NUM_WORDS; w++) begin
            sums[w] = SUM_LEN'(columns[w]) + SUM_LEN'(folded[w]); // low column plus fold.
        end
    end

    assign next_limbs = fold_normalize(sums);

endmodule

/* design/high_fold.sv */
module high_fold (
    input  vdf_pkg::column_vec_t columns,
    output vdf_pkg::limb_vec_t   folded
);
    import vdf_pkg::*;

    sum_vec_t sums;

    // column k weighs 2^(16k), replaced by its residue words.
    always_comb begin
        sums = '0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            for (int k = NUM_WORDS; k < 2 * NUM_WORDS; k++) begin
                sums[w] = sums[w]
                        + SUM_LEN'(columns[k]) * SUM_LEN'(FOLD_CONST[k-NUM_WORDS][w]);
            end
        end
    end

    assign folded = fold_normalize(sums);

endmodule

/* design/limb_squarer.sv */
module limb_squarer (
    input  vdf_pkg::limb_vec_t   limbs,
    output vdf_pkg::column_vec_t columns
);
    import vdf_pkg::*;

    column_vec_t raw;
    column_vec_t pass1;

    // move each column's bits above WORD_LEN into the next column.
    function automatic column_vec_t carry_pass(input column_vec_t cols);
        column_vec_t out;
        out[0] = COL_LEN'(cols[0][WORD_LEN-1:0]);
        for (int k = 1; k < 2 * NUM_WORDS - 1; k++) begin
            out[k] = COL_LEN'(cols[k][WORD_LEN-1:0]) + (cols[k-1] >> WORD_LEN);
        end
        // top column keeps everything it gets.
        out[2*NUM_WORDS-1] = cols[2*NUM_WORDS-1] + (cols[2*NUM_WORDS-2] >> WORD_LEN);
        return out;
    endfunction

    always_comb begin
        raw = '0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            for (int j = i; j < NUM_WORDS; j++) begin
                if (i == j) begin
                    raw[i+j] = raw[i+j] + COL_LEN'(limbs[i]) * COL_LEN'(limbs[j]);
                end else begin
                    // symmetric pair counted once and doubled.
                    raw[i+j] = raw[i+j] + ((COL_LEN'(limbs[i]) * COL_LEN'(limbs[j])) << 1);
                end
            end
        end
    end

    assign pass1   = carry_pass(raw);
    assign columns = carry_pass(pass1);

endmodule

/* design/iteration_controller.sv */
module iteration_controller (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  vdf_pkg::sq_request_t request,
    input  vdf_pkg::limb_vec_t   next_limbs,
    input  logic                 done,
    output vdf_pkg::limb_vec_t   limbs,
    output logic                 finish_load,
    output logic                 busy,
    output logic                 valid
);
    import vdf_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SQUARE,
        FINISH
    } state_t;

    state_t               state;
    logic [COUNT_LEN-1:0] remaining;
    sq_request_t          pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            remaining   <= '0;
            finish_load <= 1'b0;
            valid       <= 1'b0;
        end else begin
            finish_load <= 1'b0;
            valid       <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    remaining <= pending.iterations;
                    if (pending.iterations == '0) begin
                        state       <= FINISH;  // nothing to square.
                        finish_load <= 1'b1;
                    end else begin
                        state <= SQUARE;
                    end
                end
                SQUARE: begin
                    remaining <= remaining - 1'b1;
                    if (remaining == COUNT_LEN'(1)) begin
                        state       <= FINISH;
                        finish_load <= 1'b1;
                    end
                end
                FINISH: begin
                    if (done) begin
                        state <= IDLE;
                        valid <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            pending <= request;
        end
        if (state == LOAD) begin
            for (int w = 0; w < NUM_WORDS; w++) begin
                limbs[w] <= {1'b0, pending.operand[w*WORD_LEN +: WORD_LEN]};
            end
        end else if (state == SQUARE) begin
            limbs <= next_limbs;
        end
    end

    assign busy = (state != IDLE);

endmodule

/* design/vdf_pkg.sv */
package vdf_pkg;

    localparam int NUM_WORDS = 4;
    localparam int WORD_LEN  = 16;
    localparam int BIT_LEN   = WORD_LEN + 1;        // one redundant bit per limb.
    localparam int VALUE_LEN = NUM_WORDS * WORD_LEN;
    localparam int COUNT_LEN = 16;
    localparam int COL_LEN   = 40;
    localparam int SUM_LEN   = COL_LEN + WORD_LEN + 2; // per position fold sum.

    // prime 2^64 - 59 keeps every fold residue small.
    localparam logic [VALUE_LEN-1:0] MODULUS = 64'hFFFF_FFFF_FFFF_FFC5;

    typedef logic [NUM_WORDS-1:0][BIT_LEN-1:0]                limb_vec_t;
    typedef logic [2*NUM_WORDS-1:0][COL_LEN-1:0]              column_vec_t;
    typedef logic [NUM_WORDS-1:0][SUM_LEN-1:0]                sum_vec_t;
    typedef logic [NUM_WORDS-1:0][NUM_WORDS-1:0][WORD_LEN-1:0] fold_table_t;

    typedef struct packed {
        logic [VALUE_LEN-1:0] operand;
        logic [COUNT_LEN-1:0] iterations;
    } sq_request_t;

    // 2^(16k) mod MODULUS for the high columns k = NUM_WORDS .. 2*NUM_WORDS-1.
    function automatic fold_table_t fold_table();
        fold_table_t        residues;
        logic [VALUE_LEN:0] power;
        residues = '0;
        power    = {{VALUE_LEN{1'b0}}, 1'b1};
        for (int b = 1; b <= WORD_LEN * (2 * NUM_WORDS - 1); b++) begin
            power = power << 1;
            if (power >= {1'b0, MODULUS}) begin
                power = power - {1'b0, MODULUS};
            end
            if (b >= VALUE_LEN && b % WORD_LEN == 0) begin
                residues[b / WORD_LEN - NUM_WORDS] = power[VALUE_LEN-1:0];
            end
        end
        return residues;
    endfunction

    localparam fold_table_t FOLD_CONST = fold_table();

    // ripple the position sums into words, then bring bit 64 and up back in
    // through 2^64 mod MODULUS.
    function automatic limb_vec_t fold_normalize(input sum_vec_t sums);
        logic [SUM_LEN-1:0]   acc;
        logic [SUM_LEN-1:0]   carry;
        logic [VALUE_LEN-1:0] words;
        logic [VALUE_LEN:0]   value;
        limb_vec_t            limbs;
        carry = '0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            acc = sums[w] + carry;
            words[w*WORD_LEN +: WORD_LEN] = acc[WORD_LEN-1:0];
            carry = acc >> WORD_LEN;
        end
        value = {1'b0, words} + (VALUE_LEN+1)'(carry) * {1'b0, FOLD_CONST[0]};
        for (int w = 0; w < NUM_WORDS - 1; w++) begin
            limbs[w] = {1'b0, value[w*WORD_LEN +: WORD_LEN]};
        end
        limbs[NUM_WORDS-1] = value[VALUE_LEN:(NUM_WORDS-1)*WORD_LEN]; // top limb keeps bit 64.
        return limbs;
    endfunction

endpackage
